// ==== verif/video_trace.txt ====
# W adr data = bus write, R adr expected = bus read of wb_dat_r
# P h v expected = beam at (h, v), expected pix_color; all fields hex
W 1400 12
W 1401 34
R 1400 12
R 1401 34
W 1402 5a
W 1800 77
R 1402 00
R 1800 00
R 1400 12
R 1401 34
R 0285 00
W 1400 00
W 1401 00
W 10a2 00
W 12a2 00
W 0285 07
W 0a85 0c
P 14 28 07
P 14 a8 0c
W 0285 03
P 14 a8 0c
P 14 28 03
P 17 2b 03
W 1063 00
W 1263 00
W 10e3 00
W 1400 f8
W 1401 10
R 1400 f8
P 1c 18 03
P 1c 98 0c
W 1401 f0
P 1c 38 03
W 1400 00
W 1401 00
W 0410 05
W 1108 c9
P 40 40 19
W 1108 89
P 40 40 05
W 0410 00
P 40 40 19
W 1108 49
P 40 40 00
W 0410 06
P 40 40 06

// ==== src.f ====
+incdir+include
source/bus_pkg.sv
source/video_pkg.sv
source/tile_ram.sv
source/wb_video_port.sv
source/bg_layer.sv
source/overlay_layer.sv
source/layer_mixer.sv
source/video_top.sv
verif/video_props.sv
verif/tb_video.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the video mixer testbench with verilator, run it, check the log
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_video -o vtb_video

./obj_dir/vtb_video +verilator+error+limit+1000 > "$log" 2>&1 || true
cat "$log"

if grep -qF "*** PASSED ***" "$log"; then
    echo "simulation passed"
else
    echo "simulation failed, see $log"
    exit 1
fi

// ==== verif/tb_video.sv ====
// testbench for video_top where every step comes from verif/video_trace.txt
// trace lines are W adr data, R adr expected or P h v expected, all in hex
// a pixel check holds the beam with pxl_cen high and looks 3 clocks later
// run from the project root so the trace path resolves
`timescale 1ns/1ps
`include "video_defs.svh"

module tb_video import video_pkg::*; ();

    localparam string trace_file = "verif/video_trace.txt";

    logic                  clk;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`VID_ADR_W-1:0] wb_adr;
    logic [`VID_DAT_W-1:0] wb_dat_w;
    logic [`VID_DAT_W-1:0] wb_dat_r;
    logic                  wb_ack;
    logic                  pxl_cen;
    logic [`VID_POS_W-1:0] h_pos;
    logic [`VID_POS_W-1:0] v_pos;
    pal_index_t            pix_color;

    int                    fd;
    int                    code;
    int                    line_cnt;
    int                    watch_lines;
    logic [7:0]            op;
    logic [8*256-1:0]      line;
    logic [31:0]           arg_a;
    logic [31:0]           arg_b;
    logic [31:0]           arg_c;

    video_top UUT (
        .clk (clk), .rst_n (rst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .pxl_cen (pxl_cen), .h_pos (h_pos), .v_pos (v_pos),
        .pix_color (pix_color)
    );

    // 10 ns pixel clock
    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // one classic beat with signals held until ack and dropped on the next edge
    task automatic write_word(input logic [31:0] adr, input logic [31:0] dat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr[`VID_ADR_W-1:0];
        wb_dat_w <= dat[`VID_DAT_W-1:0];
        do @(negedge clk); while (!wb_ack);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // read data is sampled mid-cycle while ack is high
    task automatic read_word(input logic [31:0] adr, input logic [31:0] exp);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr[`VID_ADR_W-1:0];
        do @(negedge clk); while (!wb_ack);
        check_val("wb_dat_r", 32'(wb_dat_r), exp);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // three ticks through address fetch, colour register and mixer register
    task automatic expect_pixel(input logic [31:0] h, input logic [31:0] v,
                                input logic [31:0] exp);
        @(posedge clk);
        pxl_cen <= 1'b1;
        h_pos   <= h[`VID_POS_W-1:0];
        v_pos   <= v[`VID_POS_W-1:0];
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("pix_color", 32'(pix_color), exp);
    endtask

    // budget grows by 20 cycles per trace line plus slack
    initial begin
        wait (watch_lines > 0);
        repeat (watch_lines * 20 + 100) @(posedge clk);
        $display("simulation timed out before the trace was finished");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // a failed bound assertion ends the run at the next clock edge
    always @(posedge clk) begin
        if (UUT.u_props.fail_count != 0) begin
            abort_run("a bound assertion in video_props failed");
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        pxl_cen     = 1'b0;
        h_pos       = '0;
        v_pos       = '0;
        line_cnt    = 0;
        watch_lines = 0;

        // first pass only counts lines for the watchdog
        fd = $fopen(trace_file, "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file verif/video_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            line_cnt = line_cnt + 1;
        end
        $fclose(fd);
        if (line_cnt == 0) begin
            abort_run("the trace file is empty");
        end
        watch_lines = line_cnt;
        fd = $fopen(trace_file, "r");

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            case (op)
                "#": code = $fgets(line, fd);
                "W": begin
                    code = $fscanf(fd, " %h %h", arg_a, arg_b);
                    if (code != 2) begin
                        abort_run("malformed write line in the trace");
                    end
                    write_word(arg_a, arg_b);
                end
                "R": begin
                    code = $fscanf(fd, " %h %h", arg_a, arg_b);
                    if (code != 2) begin
                        abort_run("malformed read line in the trace");
                    end
                    read_word(arg_a, arg_b);
                end
                "P": begin
                    code = $fscanf(fd, " %h %h %h", arg_a, arg_b, arg_c);
                    if (code != 3) begin
                        abort_run("malformed pixel line in the trace");
                    end
                    expect_pixel(arg_a, arg_b, arg_c);
                end
                default: abort_run("unknown operation in the trace");
            endcase
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        repeat (2) @(posedge clk);
        if (UUT.u_props.fail_count != 0) begin
            abort_run("bound assertions in video_props reported failures");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== verif/video_props.sv ====
// concurrent checks on the wishbone ack and the pixel output of video_top
// fail_count tracks how many assertions have fired so far
`timescale 1ns/1ps

module video_props import video_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       pxl_cen,
    input pal_index_t pix_color
);

    int   fail_count = 0;
    logic cen_seen;

    // goes high at the first pixel tick after reset and stays there
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_seen <= 1'b0;
        end else if (pxl_cen) begin
            cen_seen <= 1'b1;
        end
    end

    // ack is a single cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
    else begin
        fail_count = fail_count + 1;
        $error("wb_ack stayed high for two cycles");
    end

    // ack only answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        fail_count = fail_count + 1;
        $error("wb_ack rose without cyc and stb");
    end

    // pixel output stays at reset value until the beam starts
    pix_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !cen_seen |-> pix_color == '0)
    else begin
        fail_count = fail_count + 1;
        $error("pix_color changed before the first pxl_cen");
    end

endmodule

bind video_top video_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .pxl_cen   (pxl_cen),
    .pix_color (pix_color)
);

// ==== source/video_top.sv ====
// video mixer top, wishbone port plus background, overlay and mixer
// beam position and pxl_cen come from an external timing generator
// pixel for the position at tick n appears on pix_color after tick n+2
`timescale 1ns/1ps
`include "video_defs.svh"

module video_top import video_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`VID_ADR_W-1:0] wb_adr,
    input  logic [`VID_DAT_W-1:0] wb_dat_w,
    output logic [`VID_DAT_W-1:0] wb_dat_r,
    output logic                  wb_ack,
    input  logic                  pxl_cen,
    input  logic [`VID_POS_W-1:0] h_pos,
    input  logic [`VID_POS_W-1:0] v_pos,
    output pal_index_t            pix_color
);

    logic                  bg_we;
    logic                  bg_nib;
    logic                  ov_we;
    logic [`VID_BG_AW-1:0] waddr;
    logic [`VID_DAT_W-1:0] wdata;
    logic [`VID_POS_W-1:0] hscroll;
    logic [`VID_POS_W-1:0] vscroll;
    colour_t               bg_color;
    ov_tile_t              ov_tile;

    wb_video_port u_port (
        .clk (clk), .rst_n (rst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w),
        .wb_ack (wb_ack), .wb_dat_r (wb_dat_r),
        .bg_we (bg_we), .bg_nib (bg_nib), .ov_we (ov_we),
        .waddr (waddr), .wdata (wdata),
        .hscroll (hscroll), .vscroll (vscroll)
    );

    // background only takes the low nibble of the bus byte
    bg_layer u_bg (
        .clk (clk), .rst_n (rst_n), .pxl_cen (pxl_cen),
        .h_pos (h_pos), .v_pos (v_pos),
        .hscroll (hscroll), .vscroll (vscroll),
        .bg_we (bg_we), .bg_nib (bg_nib),
        .waddr (waddr), .wdata (wdata[`VID_COLOR_W-1:0]),
        .bg_color (bg_color)
    );

    // overlay ram is half the size, so it sees the low address bits
    overlay_layer u_ov (
        .clk (clk), .rst_n (rst_n), .pxl_cen (pxl_cen),
        .h_pos (h_pos), .v_pos (v_pos),
        .ov_we (ov_we), .waddr (waddr[`VID_OV_AW-1:0]), .wdata (wdata),
        .ov_tile (ov_tile)
    );

    layer_mixer u_mix (
        .clk (clk), .rst_n (rst_n), .pxl_cen (pxl_cen),
        .bg_color (bg_color), .ov_tile (ov_tile),
        .pix_color (pix_color)
    );

endmodule

// ==== source/layer_mixer.sv ====
// picks overlay or background for each pixel
// overlay needs the opaque flag, then priority or a zero background
// output is a registered palette index, layer bit set for the overlay
`timescale 1ns/1ps

module layer_mixer import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  colour_t    bg_color,
    input  ov_tile_t   ov_tile,
    output pal_index_t pix_color
);

    logic ov_wins;

    // colour 0 in the background counts as transparent for the overlay test
    assign ov_wins = ov_tile.opaque && (ov_tile.prio || bg_color == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_color <= '0;
        end else if (pxl_cen) begin
            if (ov_wins) begin
                pix_color.layer <= 1'b1;
                pix_color.color <= ov_tile.color;
            end else begin
                // background also covers a transparent overlay
                pix_color.layer <= 1'b0;
                pix_color.color <= bg_color;
            end
        end
    end

endmodule

// ==== source/overlay_layer.sv ====
// fixed overlay, 32x32 map of 8x8 tiles
// each tile is one colour plus opaque and priority flags, no scrolling
// a cpu write steals the ram port for its cycle, that pixel is undefined
`timescale 1ns/1ps
`include "video_defs.svh"

module overlay_layer import video_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic [`VID_POS_W-1:0] h_pos,
    input  logic [`VID_POS_W-1:0] v_pos,
    input  logic                  ov_we,
    input  logic [`VID_OV_AW-1:0] waddr,
    input  logic [`VID_DAT_W-1:0] wdata,
    output ov_tile_t              ov_tile
);

    logic [`VID_OV_AW-1:0] ram_addr;
    ov_tile_t              ram_q;

    // tile row from v_pos, tile column from h_pos
    assign ram_addr = ov_we ? waddr : {v_pos[7:3], h_pos[7:3]};

    // the bus byte maps straight onto the attribute layout
    tile_ram #(.word_t(ov_tile_t), .aw(`VID_OV_AW)) u_ram (
        .clk  (clk),
        .addr (ram_addr),
        .we   (ov_we),
        .din  (ov_tile_t'(wdata)),
        .q    (ram_q)
    );

    // whole attribute word goes to the mixer, aligned with bg_color
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ov_tile <= '0;
        end else if (pxl_cen) begin
            ov_tile <= ram_q;
        end
    end

endmodule

// ==== source/bg_layer.sv ====
// scrolled background, 64x64 map of 4x4 cells with 4-bit colours
// one ram word carries a cell of the top half and one of the bottom half
// a cpu write steals the ram port for its cycle, that pixel is undefined
`timescale 1ns/1ps
`include "video_defs.svh"

module bg_layer import video_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic [`VID_POS_W-1:0] h_pos,
    input  logic [`VID_POS_W-1:0] v_pos,
    input  logic [`VID_POS_W-1:0] hscroll,
    input  logic [`VID_POS_W-1:0] vscroll,
    input  logic                  bg_we,
    input  logic                  bg_nib,
    input  logic [`VID_BG_AW-1:0] waddr,
    input  colour_t               wdata,
    output colour_t               bg_color
);

    logic [`VID_POS_W-1:0] sh;
    logic [`VID_POS_W-1:0] sv;
    logic [`VID_BG_AW-1:0] ram_addr;
    logic                  top_we;
    logic                  bottom_we;
    logic                  half_sel;
    bg_word_t              ram_q;

    // scrolled beam position, wraps at 256
    assign sh = h_pos + hscroll;
    assign sv = v_pos + vscroll;

    // cpu write wins the port over the display fetch
    assign ram_addr  = bg_we ? waddr : {sv[6:2], sh[7:2]};
    assign top_we    = bg_we && !bg_nib;
    assign bottom_we = bg_we && bg_nib;

    // one lane per nibble so a write never has to read the other half
    tile_ram #(.word_t(colour_t), .aw(`VID_BG_AW)) u_top (
        .clk  (clk),
        .addr (ram_addr),
        .we   (top_we),
        .din  (wdata),
        .q    (ram_q.top)
    );

    tile_ram #(.word_t(colour_t), .aw(`VID_BG_AW)) u_bottom (
        .clk  (clk),
        .addr (ram_addr),
        .we   (bottom_we),
        .din  (wdata),
        .q    (ram_q.bottom)
    );

    // sv[7] waits one tick alongside the ram read, then picks the half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_sel <= 1'b0;
            bg_color <= '0;
        end else if (pxl_cen) begin
            half_sel <= sv[7];
            bg_color <= half_sel ? ram_q.bottom : ram_q.top;
        end
    end

endmodule

// ==== source/wb_video_port.sv ====
// wishbone classic slave for the video layers
// ack comes one cycle after cyc and stb and lasts one cycle
// ram writes and scroll updates land on the edge that raises ack
// ram reads return zero, unmapped writes are acked and dropped
`timescale 1ns/1ps
`include "video_defs.svh"

module wb_video_port import bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`VID_ADR_W-1:0] wb_adr,
    input  logic [`VID_DAT_W-1:0] wb_dat_w,
    output logic                  wb_ack,
    output logic [`VID_DAT_W-1:0] wb_dat_r,
    output logic                  bg_we,
    output logic                  bg_nib,
    output logic                  ov_we,
    output logic [`VID_BG_AW-1:0] waddr,
    output logic [`VID_DAT_W-1:0] wdata,
    output logic [`VID_POS_W-1:0] hscroll,
    output logic [`VID_POS_W-1:0] vscroll
);

    wb_decode_t dec;
    logic       wr_cycle;

    // address decode, bg ram owns everything below 0x1000
    always_comb begin
        dec.nib  = wb_adr[`VID_BG_AW];
        dec.word = wb_adr[`VID_BG_AW-1:0];
        if (!wb_adr[`VID_ADR_W-1]) begin
            dec.region = BG_RAM;
        end else if (wb_adr[`VID_ADR_W-1:`VID_OV_AW] ==
                     3'(`VID_OV_BASE >> `VID_OV_AW)) begin
            dec.region = OV_RAM;
        end else if (wb_adr == `VID_REG_HSCROLL || wb_adr == `VID_REG_VSCROLL) begin
            dec.region = SCROLL_REG;
        end else begin
            dec.region = UNMAPPED;
        end
    end

    // a write is live only in the cycle before ack goes high
    assign wr_cycle = wb_cyc && wb_stb && wb_we && !wb_ack;

    // strobes to the layers, the ram samples them on the ack edge
    assign bg_we  = wr_cycle && (dec.region == BG_RAM);
    assign ov_we  = wr_cycle && (dec.region == OV_RAM);
    assign bg_nib = dec.nib;
    assign waddr  = dec.word;
    assign wdata  = wb_dat_w;

    // ack toggles off after each beat, so a held stb acks every second cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (wr_cycle && dec.region == SCROLL_REG) begin
            if (wb_adr == `VID_REG_VSCROLL) begin
                vscroll <= wb_dat_w;
            end else begin
                hscroll <= wb_dat_w;
            end
        end
    end

    // only the scroll registers read back
    always_comb begin
        wb_dat_r = '0;
        if (dec.region == SCROLL_REG) begin
            wb_dat_r = (wb_adr == `VID_REG_VSCROLL) ? vscroll : hscroll;
        end
    end

endmodule

// ==== source/tile_ram.sv ====
// single port ram with synchronous read, one word per address
// read returns the old word when read and write hit the same address
// contents are not initialised, the caller arbitrates the port
`timescale 1ns/1ps

module tile_ram #(
    parameter type word_t = logic [7:0],
    parameter int  aw     = 10
) (
    input  logic          clk,
    input  logic [aw-1:0] addr,
    input  logic          we,
    input  word_t         din,
    output word_t         q
);

    word_t mem [2**aw];

    // q follows the address of the previous clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        q <= mem[addr];
    end

endmodule

// ==== source/video_pkg.sv ====
// payload types carried between the layers and the mixer
// colour width comes from the shared defines header
`include "video_defs.svh"

package video_pkg;

    // one 4-bit colour, used on its own for a background nibble lane
    typedef logic [`VID_COLOR_W-1:0] colour_t;

    // background map word
    // top half of the screen in the low nibble, bottom half in the high one
    typedef struct packed {
        colour_t bottom;
        colour_t top;
    } bg_word_t;

    // overlay tile attributes, one solid colour per 8x8 tile
    typedef struct packed {
        logic       opaque;
        logic       prio;
        logic [1:0] spare;
        colour_t    color;
    } ov_tile_t;

    // palette index, layer bit set when the overlay won the pixel
    typedef struct packed {
        logic    layer;
        colour_t color;
    } pal_index_t;

endpackage

// ==== source/bus_pkg.sv ====
// wishbone decode types for the video register map
// region boundaries are listed with the defines in the shared header
`include "video_defs.svh"

package bus_pkg;

    // which target a bus address falls into
    typedef enum logic [1:0] {
        BG_RAM,
        OV_RAM,
        SCROLL_REG,
        UNMAPPED
    } wb_region_t;

    // result of the address decode
    // nib and word only mean something for the map rams
    typedef struct packed {
        wb_region_t            region;
        logic                  nib;
        logic [`VID_BG_AW-1:0] word;
    } wb_decode_t;

endpackage

// ==== include/video_defs.svh ====
// sizes and register map shared by the video RTL and its testbench
// the wishbone bus is word addressed, one byte per word
// beam coordinates are 8 bits and wrap at 256
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// beam position and bus data widths
`define VID_POS_W       8
`define VID_DAT_W       8

// all layer colours are 4 bits
`define VID_COLOR_W     4

// background map ram, 64x32 cells, two screen halves per word
`define VID_BG_AW       11
// overlay map ram, 32x32 tiles
`define VID_OV_AW       10

// wishbone word address and register map
`define VID_ADR_W       13
`define VID_OV_BASE     13'h1000
`define VID_REG_HSCROLL 13'h1400
`define VID_REG_VSCROLL 13'h1401

`endif
